// ==== hw/tinker_pkg.sv ====
package tinker_pkg;

    localparam int data_width     = 64;
    localparam int instr_width    = 32;
    localparam int addr_width     = 32; // byte address
    localparam int reg_addr_width = 5;
    localparam int lit_width      = 12;
    localparam int instr_bytes    = 4;  // pc step

    // encodings follow the tinker isa, float/div/call/return left out
    typedef enum logic [4:0] {
        op_and    = 5'h00,
        op_or     = 5'h01,
        op_xor    = 5'h02,
        op_not    = 5'h03,
        op_shftr  = 5'h04,
        op_shftri = 5'h05,
        op_shftl  = 5'h06,
        op_shftli = 5'h07,
        op_br     = 5'h08, // pc = rd
        op_brr    = 5'h09, // pc += rd
        op_brr_l  = 5'h0a, // pc += sext(L)
        op_brnz   = 5'h0b,
        op_brgt   = 5'h0e,
        op_halt   = 5'h0f,
        op_load   = 5'h10, // mov rd, (rs)(L)
        op_mov    = 5'h11,
        op_mov_l  = 5'h12, // low 12 bits only
        op_store  = 5'h13, // mov (rd)(L), rs
        op_add    = 5'h18,
        op_addi   = 5'h19,
        op_sub    = 5'h1a,
        op_subi   = 5'h1b,
        op_mul    = 5'h1c
    } opcode_t;

    // operand source for the ex stage
    typedef enum logic [1:0] {
        fwd_regfile,
        fwd_exmem,
        fwd_memwb
    } fwd_sel_t;

endpackage

// ==== hw/tinker_alu.sv ====
`timescale 1ns/1ns

module tinker_alu import tinker_pkg::*; (
    input  opcode_t               opcode,
    input  logic [data_width-1:0] rd_val,
    input  logic [data_width-1:0] rs_val,
    input  logic [data_width-1:0] rt_val,
    input  logic [lit_width-1:0]  lit,
    output logic [data_width-1:0] result
);

    logic [data_width-1:0] lit_zext, lit_sext;

    assign lit_zext = {{(data_width-lit_width){1'b0}}, lit};
    assign lit_sext = {{(data_width-lit_width){lit[lit_width-1]}}, lit};

    always_comb begin
        case (opcode)
            op_add:    result = rs_val + rt_val;
            op_addi:   result = rd_val + lit_zext; // rd is source and dest
            op_sub:    result = rs_val - rt_val;
            op_subi:   result = rd_val - lit_zext;
            op_mul:    result = rs_val * rt_val;   // low 64 bits
            op_and:    result = rs_val & rt_val;
            op_or:     result = rs_val | rt_val;
            op_xor:    result = rs_val ^ rt_val;
            op_not:    result = ~rs_val;
            op_shftr:  result = rs_val >> rt_val;
            op_shftri: result = rd_val >> lit_zext;
            op_shftl:  result = rs_val << rt_val;
            op_shftli: result = rd_val << lit_zext;
            op_mov:    result = rs_val;
            op_mov_l:  result = {rd_val[data_width-1:lit_width], lit};
            op_load:   result = rs_val + lit_sext; // byte address
            op_store:  result = rd_val + lit_sext;
            default:   result = '0;
        endcase
    end

endmodule

// ==== hw/tinker_branch.sv ====
`timescale 1ns/1ns

module tinker_branch import tinker_pkg::*; (
    input  opcode_t               opcode,
    input  logic [addr_width-1:0] pc,     // pc of the branch itself
    input  logic [lit_width-1:0]  lit,
    input  logic [data_width-1:0] rd_val,
    input  logic [data_width-1:0] rs_val,
    input  logic [data_width-1:0] rt_val,
    output logic                  take_branch,
    output logic [addr_width-1:0] branch_target
);

    logic [addr_width-1:0] lit_sext;

    assign lit_sext = {{(addr_width-lit_width){lit[lit_width-1]}}, lit};

    always_comb begin
        take_branch   = 1'b0;
        branch_target = pc + addr_width'(instr_bytes); // fall through
        case (opcode)
            op_br: begin
                take_branch   = 1'b1;
                branch_target = rd_val[addr_width-1:0];
            end
            op_brr: begin
                take_branch   = 1'b1;
                branch_target = pc + rd_val[addr_width-1:0];
            end
            op_brr_l: begin
                take_branch   = 1'b1;
                branch_target = pc + lit_sext;
            end
            op_brnz: if (rs_val != '0) begin
                take_branch   = 1'b1;
                branch_target = rd_val[addr_width-1:0];
            end
            op_brgt: if ($signed(rs_val) > $signed(rt_val)) begin // signed compare
                take_branch   = 1'b1;
                branch_target = rd_val[addr_width-1:0];
            end
            default: ;
        endcase
    end

endmodule

// ==== hw/tinker_decoder.sv ====
`timescale 1ns/1ns

module tinker_decoder import tinker_pkg::*; (
    input  logic [instr_width-1:0]    instr,
    input  logic                      valid,     // low for bubbles
    output opcode_t                   opcode,
    output logic [reg_addr_width-1:0] rd,
    output logic [reg_addr_width-1:0] rs,
    output logic [reg_addr_width-1:0] rt,
    output logic [lit_width-1:0]      lit,
    output logic                      reg_write,
    output logic                      mem_read,
    output logic                      mem_write,
    output logic                      is_branch,
    output logic                      halt
);

    assign opcode = opcode_t'(instr[31:27]);
    assign rd     = instr[26:22];
    assign rs     = instr[21:17];
    assign rt     = instr[16:12];
    assign lit    = instr[11:0];

    always_comb begin
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        is_branch = 1'b0;
        halt      = 1'b0;
        if (valid) begin
            case (opcode)
                op_and, op_or, op_xor, op_not, op_shftr, op_shftri, op_shftl, op_shftli,
                op_mov, op_mov_l, op_add, op_addi, op_sub, op_subi, op_mul:
                    reg_write = 1'b1;
                op_load: begin
                    reg_write = 1'b1;
                    mem_read  = 1'b1;
                end
                op_store: mem_write = 1'b1;
                op_br, op_brr, op_brr_l, op_brnz, op_brgt: is_branch = 1'b1;
                op_halt: halt = 1'b1;
                default: ; // undefined opcode acts as a nop
            endcase
        end
    end

endmodule

// ==== hw/tinker_hazard.sv ====
`timescale 1ns/1ns

module tinker_hazard import tinker_pkg::*; (
    input  logic [reg_addr_width-1:0] id_rd,
    input  logic [reg_addr_width-1:0] id_rs,
    input  logic [reg_addr_width-1:0] id_rt,
    input  logic                      id_is_branch,
    input  logic [reg_addr_width-1:0] idex_rd,
    input  logic [reg_addr_width-1:0] idex_rs,  // sources of the instruction in EX
    input  logic [reg_addr_width-1:0] idex_rt,
    input  logic                      idex_reg_write,
    input  logic                      idex_mem_read,
    input  logic [reg_addr_width-1:0] exmem_rd,
    input  logic                      exmem_reg_write,
    input  logic [reg_addr_width-1:0] memwb_rd,
    input  logic                      memwb_reg_write,
    output logic                      stall,
    output fwd_sel_t                  sel_rd,
    output fwd_sel_t                  sel_rs,
    output fwd_sel_t                  sel_rt
);

    logic idex_hit, exmem_hit;

    // newest producer first
    function automatic fwd_sel_t pick(
        input logic [reg_addr_width-1:0] src,
        input logic [reg_addr_width-1:0] ex_rd,
        input logic                      ex_we,
        input logic [reg_addr_width-1:0] wb_rd,
        input logic                      wb_we
    );
        if (ex_we && ex_rd == src) return fwd_exmem;
        if (wb_we && wb_rd == src) return fwd_memwb;
        return fwd_regfile;
    endfunction

    assign sel_rd = pick(idex_rd, exmem_rd, exmem_reg_write, memwb_rd, memwb_reg_write);
    assign sel_rs = pick(idex_rs, exmem_rd, exmem_reg_write, memwb_rd, memwb_reg_write);
    assign sel_rt = pick(idex_rt, exmem_rd, exmem_reg_write, memwb_rd, memwb_reg_write);

    assign idex_hit  = idex_rd == id_rd || idex_rd == id_rs || idex_rd == id_rt;
    assign exmem_hit = exmem_rd == id_rd || exmem_rd == id_rs || exmem_rd == id_rt;

    // load-use, or a branch whose operand is not yet in the regfile
    assign stall = (idex_mem_read && idex_hit) ||
                   (id_is_branch && ((idex_reg_write && idex_hit) ||
                                     (exmem_reg_write && exmem_hit)));

endmodule

// ==== hw/tinker_regfile.sv ====
`timescale 1ns/1ns

module tinker_regfile import tinker_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      we,
    input  logic [reg_addr_width-1:0] wr_addr,
    input  logic [data_width-1:0]     wr_data,
    input  logic [reg_addr_width-1:0] rd_addr,
    input  logic [reg_addr_width-1:0] rs_addr,
    input  logic [reg_addr_width-1:0] rt_addr,
    output logic [data_width-1:0]     rd_data,
    output logic [data_width-1:0]     rs_data,
    output logic [data_width-1:0]     rt_data
);

    logic [data_width-1:0] regs [2**reg_addr_width];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2**reg_addr_width; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // write-through, WB value visible to ID in the same cycle
    assign rd_data = (we && wr_addr == rd_addr) ? wr_data : regs[rd_addr];
    assign rs_data = (we && wr_addr == rs_addr) ? wr_data : regs[rs_addr];
    assign rt_data = (we && wr_addr == rt_addr) ? wr_data : regs[rt_addr];

endmodule

// ==== hw/tinker_memory.sv ====
`timescale 1ns/1ns

module tinker_memory import tinker_pkg::*; #(
    parameter int mem_bytes = 16384
) (
    input  logic                   clk,
    input  logic [addr_width-1:0]  fetch_addr,
    output logic [instr_width-1:0] fetch_instr,
    input  logic [addr_width-1:0]  data_addr,
    output logic [data_width-1:0]  data_rdata,
    input  logic                   store_we,
    input  logic [data_width-1:0]  store_data,
    input  logic                   load_we,
    input  logic [addr_width-1:0]  load_addr,
    input  logic [instr_width-1:0] load_data
);

    localparam int idx_width = $clog2(mem_bytes);

    logic [7:0] bytes_q [mem_bytes];

    // little endian, index wraps modulo mem_bytes
    always_comb begin
        for (int i = 0; i < instr_width / 8; i++) begin
            fetch_instr[8*i +: 8] = bytes_q[fetch_addr[idx_width-1:0] + idx_width'(i)];
        end
        for (int i = 0; i < data_width / 8; i++) begin
            data_rdata[8*i +: 8] = bytes_q[data_addr[idx_width-1:0] + idx_width'(i)];
        end
    end

    always_ff @(posedge clk) begin
        if (load_we) begin // load port wins
            for (int i = 0; i < instr_width / 8; i++) begin
                bytes_q[load_addr[idx_width-1:0] + idx_width'(i)] <= load_data[8*i +: 8];
            end
        end else if (store_we) begin
            for (int i = 0; i < data_width / 8; i++) begin
                bytes_q[data_addr[idx_width-1:0] + idx_width'(i)] <= store_data[8*i +: 8];
            end
        end
    end

endmodule

// ==== hw/tinker_core.sv ====
`timescale 1ns/1ns

module tinker_core import tinker_pkg::*; #(
    parameter logic [addr_width-1:0] pc_reset = 32'h2000
) (
    input  logic                   clk,
    input  logic                   reset,
    output logic [addr_width-1:0]  fetch_addr,
    input  logic [instr_width-1:0] fetch_instr,
    output logic [addr_width-1:0]  data_addr,
    input  logic [data_width-1:0]  data_rdata,
    output logic                   store_we,
    output logic [data_width-1:0]  store_data,
    output logic                   hlt
);

    logic [addr_width-1:0]     pc;
    logic                      halting;     // halt seen in ID, fetch frozen
    logic [addr_width-1:0]     ifid_pc;
    logic [instr_width-1:0]    ifid_instr;
    logic                      ifid_valid;

    opcode_t                   id_opcode;
    logic [reg_addr_width-1:0] id_rd, id_rs, id_rt;
    logic [lit_width-1:0]      id_lit;
    logic                      id_reg_write, id_mem_read, id_mem_write, id_is_branch, id_halt;
    logic [data_width-1:0]     id_rd_val, id_rs_val, id_rt_val;
    logic                      br_take, take_branch, stall;
    logic [addr_width-1:0]     br_target;
    fwd_sel_t                  sel_rd, sel_rs, sel_rt;

    logic                      idex_reg_write, idex_mem_read, idex_mem_write, idex_halt;
    opcode_t                   idex_opcode;
    logic [reg_addr_width-1:0] idex_rd, idex_rs, idex_rt;
    logic [lit_width-1:0]      idex_lit;
    logic [data_width-1:0]     idex_rd_val, idex_rs_val, idex_rt_val;
    logic [data_width-1:0]     ex_rd_val, ex_rs_val, ex_rt_val, alu_result;

    logic                      exmem_reg_write, exmem_mem_read, exmem_mem_write, exmem_halt;
    logic [reg_addr_width-1:0] exmem_rd;
    logic [data_width-1:0]     exmem_result, exmem_store_data;

    logic                      memwb_reg_write;
    logic [reg_addr_width-1:0] memwb_rd;
    logic [data_width-1:0]     memwb_data;  // load data or alu result

    assign fetch_addr = pc;
    // a branch stalled on its operands must not redirect yet
    assign take_branch = br_take && id_is_branch && !stall;

    // IF
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc         <= pc_reset;
            ifid_valid <= 1'b0;
            halting    <= 1'b0;
        end else if (!stall) begin
            if (!halting && !id_halt) begin
                pc <= take_branch ? br_target : pc + addr_width'(instr_bytes);
            end
            ifid_valid <= !(take_branch || id_halt || halting); // squash slot
            halting    <= halting || id_halt;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ifid_pc    <= pc;
            ifid_instr <= fetch_instr;
        end
    end

    // ID
    tinker_decoder tinker_decoder_i (
        .instr     (ifid_instr),
        .valid     (ifid_valid),
        .opcode    (id_opcode),
        .rd        (id_rd),
        .rs        (id_rs),
        .rt        (id_rt),
        .lit       (id_lit),
        .reg_write (id_reg_write),
        .mem_read  (id_mem_read),
        .mem_write (id_mem_write),
        .is_branch (id_is_branch),
        .halt      (id_halt)
    );

    tinker_regfile tinker_regfile_i (
        .clk     (clk),
        .reset   (reset),
        .we      (memwb_reg_write),
        .wr_addr (memwb_rd),
        .wr_data (memwb_data),
        .rd_addr (id_rd),
        .rs_addr (id_rs),
        .rt_addr (id_rt),
        .rd_data (id_rd_val),
        .rs_data (id_rs_val),
        .rt_data (id_rt_val)
    );

    tinker_branch tinker_branch_i (
        .opcode        (id_opcode),
        .pc            (ifid_pc),
        .lit           (id_lit),
        .rd_val        (id_rd_val),
        .rs_val        (id_rs_val),
        .rt_val        (id_rt_val),
        .take_branch   (br_take),
        .branch_target (br_target)
    );

    tinker_hazard tinker_hazard_i (
        .id_rd           (id_rd),
        .id_rs           (id_rs),
        .id_rt           (id_rt),
        .id_is_branch    (id_is_branch),
        .idex_rd         (idex_rd),
        .idex_rs         (idex_rs),
        .idex_rt         (idex_rt),
        .idex_reg_write  (idex_reg_write),
        .idex_mem_read   (idex_mem_read),
        .exmem_rd        (exmem_rd),
        .exmem_reg_write (exmem_reg_write),
        .memwb_rd        (memwb_rd),
        .memwb_reg_write (memwb_reg_write),
        .stall           (stall),
        .sel_rd          (sel_rd),
        .sel_rs          (sel_rs),
        .sel_rt          (sel_rt)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            idex_reg_write <= 1'b0;
            idex_mem_read  <= 1'b0;
            idex_mem_write <= 1'b0;
            idex_halt      <= 1'b0;
        end else begin // stall turns the slot into a bubble
            idex_reg_write <= id_reg_write && !stall;
            idex_mem_read  <= id_mem_read && !stall;
            idex_mem_write <= id_mem_write && !stall;
            idex_halt      <= id_halt && !stall;
        end
    end

    always_ff @(posedge clk) begin
        idex_opcode <= id_opcode;
        idex_rd     <= id_rd;
        idex_rs     <= id_rs;
        idex_rt     <= id_rt;
        idex_lit    <= id_lit;
        idex_rd_val <= id_rd_val;
        idex_rs_val <= id_rs_val;
        idex_rt_val <= id_rt_val;
    end

    // EX, forward muxes
    assign ex_rd_val = (sel_rd == fwd_exmem) ? exmem_result :
                       (sel_rd == fwd_memwb) ? memwb_data : idex_rd_val;
    assign ex_rs_val = (sel_rs == fwd_exmem) ? exmem_result :
                       (sel_rs == fwd_memwb) ? memwb_data : idex_rs_val;
    assign ex_rt_val = (sel_rt == fwd_exmem) ? exmem_result :
                       (sel_rt == fwd_memwb) ? memwb_data : idex_rt_val;

    tinker_alu tinker_alu_i (
        .opcode (idex_opcode),
        .rd_val (ex_rd_val),
        .rs_val (ex_rs_val),
        .rt_val (ex_rt_val),
        .lit    (idex_lit),
        .result (alu_result)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            exmem_reg_write <= 1'b0;
            exmem_mem_read  <= 1'b0;
            exmem_mem_write <= 1'b0;
            exmem_halt      <= 1'b0;
        end else begin
            exmem_reg_write <= idex_reg_write;
            exmem_mem_read  <= idex_mem_read;
            exmem_mem_write <= idex_mem_write;
            exmem_halt      <= idex_halt;
        end
    end

    always_ff @(posedge clk) begin
        exmem_rd         <= idex_rd;
        exmem_result     <= alu_result;
        exmem_store_data <= ex_rs_val; // store value is rs
    end

    // MEM
    assign data_addr  = exmem_result[addr_width-1:0];
    assign store_we   = exmem_mem_write;
    assign store_data = exmem_store_data;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            memwb_reg_write <= 1'b0;
            hlt             <= 1'b0;
        end else begin
            memwb_reg_write <= exmem_reg_write;
            hlt             <= hlt || exmem_halt; // sticky until reset
        end
    end

    always_ff @(posedge clk) begin
        memwb_rd   <= exmem_rd;
        memwb_data <= exmem_mem_read ? data_rdata : exmem_result;
    end

endmodule

// ==== hw/tinker_top.sv ====
`timescale 1ns/1ns

module tinker_top import tinker_pkg::*; #(
    parameter int                    mem_bytes = 16384,
    parameter logic [addr_width-1:0] pc_reset  = 32'h2000
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   load_we,   // program load, only while reset is held
    input  logic [addr_width-1:0]  load_addr,
    input  logic [instr_width-1:0] load_data,
    output logic                   store_we,
    output logic [addr_width-1:0]  store_addr,
    output logic [data_width-1:0]  store_data,
    output logic                   hlt
);

    logic [addr_width-1:0]  fetch_addr;
    logic [instr_width-1:0] fetch_instr;
    logic [data_width-1:0]  data_rdata;

    tinker_core #(
        .pc_reset (pc_reset)
    ) tinker_core_i (
        .clk         (clk),
        .reset       (reset),
        .fetch_addr  (fetch_addr),
        .fetch_instr (fetch_instr),
        .data_addr   (store_addr), // shared load/store address
        .data_rdata  (data_rdata),
        .store_we    (store_we),
        .store_data  (store_data),
        .hlt         (hlt)
    );

    tinker_memory #(
        .mem_bytes (mem_bytes)
    ) tinker_memory_i (
        .clk         (clk),
        .fetch_addr  (fetch_addr),
        .fetch_instr (fetch_instr),
        .data_addr   (store_addr),
        .data_rdata  (data_rdata),
        .store_we    (store_we),
        .store_data  (store_data),
        .load_we     (load_we),
        .load_addr   (load_addr),
        .load_data   (load_data)
    );

endmodule

// ==== test/tinker_tb_tests.svh ====
// fields: opcode 31:27, rd 26:22, rs 21:17, rt 16:12, L 11:0
function automatic logic [31:0] encode(opcode_t op, int rd, int rs, int rt, int lit);
    return {op, rd[4:0], rs[4:0], rt[4:0], lit[11:0]};
endfunction

function automatic logic [63:0] sext12(input int lit);
    return {{52{lit[11]}}, lit[11:0]};
endfunction

// fresh program, registers come out of reset as zero
task automatic new_program();
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
    mem_m.delete();
    foreach (m[i]) m[i] = '0;
endtask

// append an integer op and update the mirror by the isa rules
task automatic emit_alu(opcode_t op, int d, int s, int t, int lit);
    logic [63:0] zl;
    zl = 64'(lit[11:0]); // zero-extended L
    prog.push_back(encode(op, d, s, t, lit));
    case (op)
        op_add:    m[d] = m[s] + m[t];
        op_addi:   m[d] = m[d] + zl;    // rd is also the source
        op_sub:    m[d] = m[s] - m[t];
        op_subi:   m[d] = m[d] - zl;
        op_mul:    m[d] = m[s] * m[t];  // 64-bit wrap
        op_and:    m[d] = m[s] & m[t];
        op_or:     m[d] = m[s] | m[t];
        op_xor:    m[d] = m[s] ^ m[t];
        op_not:    m[d] = ~m[s];
        op_shftr:  m[d] = m[s] >> m[t];
        op_shftri: m[d] = m[d] >> zl;
        op_shftl:  m[d] = m[s] << m[t];
        op_shftli: m[d] = m[d] << zl;
        op_mov:    m[d] = m[s];
        op_mov_l:  m[d] = {m[d][63:12], zl[11:0]}; // low 12 bits only
        default: ;
    endcase
endtask

// store rs at rd + sext(L); a dead store sits on a path that must not run
task automatic emit_store(int base, int off, int src, bit live);
    logic [63:0] a;
    a = m[base] + sext12(off);
    prog.push_back(encode(op_store, base, src, 0, off));
    if (live) begin
        exp_addr.push_back(a[31:0]);
        exp_data.push_back(m[src]);
        mem_m[a[31:0]] = m[src];
    end
endtask

task automatic emit_load(int d, int s, int off);
    logic [63:0] a;
    a = m[s] + sext12(off);
    prog.push_back(encode(op_load, d, s, 0, off));
    m[d] = mem_m[a[31:0]];
endtask

// 3 words: reg = address two past the branch that follows
task automatic point_past_next(int r);
    int target;
    target = 4 * (prog.size() + 5);
    emit_alu(op_mov_l, r, 0, 0, int'(prog_base >> 4));
    emit_alu(op_shftli, r, 0, 0, 4);
    emit_alu(op_addi, r, 0, 0, target); // last write right before the branch
endtask

task automatic test_integer_ops();
    new_program();
    emit_alu(op_mov_l, 1, 0, 0, 'h123);
    emit_alu(op_shftli, 1, 0, 0, 20);   // rd from EX/MEM
    emit_alu(op_mov_l, 1, 0, 0, 'habc); // keeps the upper bits
    emit_alu(op_addi, 2, 0, 0, 'h7ff);
    emit_alu(op_add, 3, 1, 2, 0);       // r2 from EX/MEM, r1 from MEM/WB
    emit_alu(op_sub, 4, 3, 1, 0);
    emit_alu(op_mul, 5, 4, 3, 0);
    emit_alu(op_and, 6, 5, 1, 0);
    emit_alu(op_or, 7, 6, 5, 0);
    emit_alu(op_xor, 8, 7, 6, 0);
    emit_alu(op_not, 9, 8, 0, 0);
    emit_alu(op_subi, 9, 0, 0, 'h0f0);
    emit_alu(op_mov_l, 10, 0, 0, 3);
    emit_alu(op_shftr, 11, 9, 10, 0);
    emit_alu(op_shftl, 12, 11, 10, 0);
    emit_alu(op_shftri, 12, 0, 0, 5);
    emit_alu(op_mov, 13, 12, 0, 0);
    for (int i = 1; i <= 13; i++) begin
        emit_store(0, 'h400 + 8 * i, i, 1'b1);
    end
    prog.push_back(encode(op_halt, 0, 0, 0, 0));
    run_program("integer ops");
endtask

task automatic test_load_use();
    new_program();
    emit_alu(op_mov_l, 1, 0, 0, 'h5a5);
    emit_alu(op_shftli, 1, 0, 0, 36);
    emit_alu(op_mov_l, 1, 0, 0, 'h321);
    emit_store(0, 'h500, 1, 1'b1);
    emit_alu(op_mov_l, 2, 0, 0, 'h510);
    emit_load(3, 2, -16);               // 0x510 - 16 = 0x500
    emit_alu(op_add, 4, 3, 1, 0);       // uses the load at once
    emit_store(0, 'h508, 4, 1'b1);
    emit_load(5, 0, 'h500);
    emit_store(0, 'h510, 5, 1'b1);      // store data straight from a load
    prog.push_back(encode(op_halt, 0, 0, 0, 0));
    run_program("load-use");
endtask

task automatic test_branches();
    new_program();
    emit_alu(op_mov_l, 1, 0, 0, 1);
    emit_alu(op_not, 6, 0, 0, 0);                 // r6 = -1
    prog.push_back(encode(op_brr_l, 0, 0, 0, 8)); // over one word
    emit_store(0, 'h300, 1, 1'b0);
    emit_store(0, 'h308, 6, 1'b1);
    prog.push_back(encode(op_brnz, 0, 2, 0, 0));  // r2 zero, falls through
    emit_store(0, 'h310, 1, 1'b1);
    point_past_next(4);
    prog.push_back(encode(op_brnz, 4, 1, 0, 0));  // taken
    emit_store(0, 'h318, 1, 1'b0);
    prog.push_back(encode(op_brgt, 4, 6, 1, 0));  // -1 > 1 false when signed
    emit_store(0, 'h320, 6, 1'b1);
    point_past_next(5);
    prog.push_back(encode(op_brgt, 5, 1, 6, 0));  // 1 > -1
    emit_store(0, 'h328, 1, 1'b0);
    point_past_next(7);
    prog.push_back(encode(op_br, 7, 0, 0, 0));
    emit_store(0, 'h330, 1, 1'b0);
    emit_alu(op_mov_l, 8, 0, 0, 8);
    prog.push_back(encode(op_brr, 8, 0, 0, 0));   // pc + 8
    emit_store(0, 'h338, 1, 1'b0);
    emit_store(0, 'h340, 8, 1'b1);
    prog.push_back(encode(op_halt, 0, 0, 0, 0));
    run_program("branches");
endtask

task automatic test_halt();
    new_program();
    emit_alu(op_mov_l, 1, 0, 0, 'h77);
    emit_store(0, 'h600, 1, 1'b1);
    emit_alu(op_addi, 1, 0, 0, 1);
    emit_store(0, 'h608, 1, 1'b1); // right before the halt
    prog.push_back(encode(op_halt, 0, 0, 0, 0));
    emit_store(0, 'h610, 1, 1'b0); // never reached
    emit_store(0, 'h618, 1, 1'b0);
    run_program("halt");
endtask

task automatic test_random_arith();
    int shift;
    new_program();
    for (int k = 0; k < 4; k++) begin
        shift = $urandom % 48;
        emit_alu(op_mov_l, 1, 0, 0, $urandom);
        emit_alu(op_shftli, 1, 0, 0, shift); // spread the operand over 64 bits
        emit_alu(op_mov_l, 1, 0, 0, $urandom);
        emit_alu(op_addi, 2, 0, 0, $urandom);
        emit_alu(op_sub, 3, 1, 2, 0);
        emit_alu(op_mul, 4, 3, 1, 0);
        emit_alu(op_addi, 4, 0, 0, $urandom);
        emit_store(0, 'h700 + 8 * k, 4, 1'b1);
    end
    prog.push_back(encode(op_halt, 0, 0, 0, 0));
    run_program("random arith");
endtask

// ==== test/tinker_tb.sv ====
`timescale 1ns/1ns

module tinker_tb import tinker_pkg::*;;

    localparam logic [31:0] prog_base  = 32'h2000; // pc_reset of tinker_top
    // five programs of at most 40 words: load + 8 reset + ~100 run cycles each, doubled
    localparam int          max_cycles = 2000;

    logic                   clk;
    logic                   reset;
    logic                   load_we;
    logic [addr_width-1:0]  load_addr;
    logic [instr_width-1:0] load_data;
    logic                   store_we;
    logic [addr_width-1:0]  store_addr;
    logic [data_width-1:0]  store_data;
    logic                   hlt;

    int errors = 0;
    int cycles = 0;

    logic [31:0] prog [$];        // program words, loaded from prog_base
    logic [31:0] seen_addr [$];   // stores observed at the top
    logic [63:0] seen_data [$];
    logic [31:0] exp_addr [$];    // stores the program should make
    logic [63:0] exp_data [$];
    logic [63:0] m [32];          // register mirror
    logic [63:0] mem_m [logic [31:0]]; // data memory mirror

    tinker_top tinker_top_i (
        .clk        (clk),
        .reset      (reset),
        .load_we    (load_we),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .store_we   (store_we),
        .store_addr (store_addr),
        .store_data (store_data),
        .hlt        (hlt)
    );

    always #10 clk = ~clk; // 20 ns period

    // store monitor, outputs are settled by the falling edge
    always @(negedge clk) begin
        if (store_we) begin
            seen_addr.push_back(store_addr);
            seen_data.push_back(store_data);
        end
    end

    // run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: hlt did not rise within %0d cycles", max_cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // load prog during reset, run to halt, compare the stores
    task automatic run_program(input string name);
        int n;
        @(negedge clk);
        reset = 1'b1;
        for (int i = 0; i < prog.size(); i++) begin
            load_we   = 1'b1;
            load_addr = prog_base + 32'(4 * i);
            load_data = prog[i];
            @(negedge clk);
        end
        load_we = 1'b0;
        repeat (8) @(negedge clk);
        seen_addr.delete();
        seen_data.delete();
        reset = 1'b0;
        while (hlt !== 1'b1) @(negedge clk);
        if (seen_addr.size() < exp_addr.size()) begin // older stores must be out by now
            errors++;
            $display("%s: only %0d of %0d stores had appeared when hlt rose",
                     name, seen_addr.size(), exp_addr.size());
        end
        repeat (10) @(negedge clk); // room for a stray store
        check_value({name, " hlt"}, 64'(hlt), 64'd1);
        n = (seen_addr.size() < exp_addr.size()) ? seen_addr.size() : exp_addr.size();
        for (int i = 0; i < n; i++) begin
            check_value($sformatf("%s store_addr[%0d]", name, i),
                        64'(seen_addr[i]), 64'(exp_addr[i]));
            check_value($sformatf("%s store_data[%0d]", name, i), seen_data[i], exp_data[i]);
        end
        if (seen_addr.size() != exp_addr.size()) begin
            errors++;
            $display("%s: %0d stores seen but %0d expected",
                     name, seen_addr.size(), exp_addr.size());
        end
    endtask

    `include "tinker_tb_tests.svh"

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        load_we   = 1'b0;
        load_addr = '0;
        load_data = '0;
        void'($urandom(29));
        test_integer_ops();
        test_load_use();
        test_branches();
        test_halt();
        test_random_arith();
        $display("errors: %0d, cycles: %0d", errors, cycles);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== tinker.f ====
+incdir+test
hw/tinker_pkg.sv
hw/tinker_alu.sv
hw/tinker_branch.sv
hw/tinker_decoder.sv
hw/tinker_hazard.sv
hw/tinker_regfile.sv
hw/tinker_memory.sv
hw/tinker_core.sv
hw/tinker_top.sv
test/tinker_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the tinker testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tinker_tb -f tinker.f -o tinker_sim

# the simulation itself exits 0, the verdict comes from its output
out=$(./obj_dir/tinker_sim)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx '=== PASS ==='
